/* logic/calc_num_pkg.sv */
package calc_num_pkg;

    // Keypad digit code width
    parameter int DIGIT_WIDTH = 4;

    // Each new digit scales the running value by this base
    parameter int DECIMAL_BASE = 10;

    // Operand and result width unless the top level overrides it
    parameter int DEFAULT_DATA_WIDTH = 16;

endpackage

/* logic/calc_op_pkg.sv */
package calc_op_pkg;

    // Width of the one-hot operator code
    parameter int OP_WIDTH = 3;

    // Any code other than the three below is not an operator
    typedef logic [OP_WIDTH-1:0] op_t;

    parameter op_t OP_ADD = 3'b001;     // Addition
    parameter op_t OP_SUB = 3'b010;     // Subtraction
    parameter op_t OP_MUL = 3'b100;     // Multiplication

endpackage

/* logic/digit_accumulator.sv */
module digit_accumulator import calc_num_pkg::*; #(
    parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH
) (
    input  logic                   clk,
    input  logic                   nRST,
    input  logic                   digit_en,           // One-cycle digit strobe
    input  logic                   clear,              // Start a fresh operand
    input  logic [DIGIT_WIDTH-1:0] keypad_input,
    output logic [DATA_WIDTH-1:0]  value
);

    logic                  digit_valid;
    logic [DATA_WIDTH-1:0] digit_ext;
    logic [DATA_WIDTH-1:0] times_ten;
    logic [DATA_WIDTH-1:0] next_value;

    // Codes ten and above are not decimal digits
    assign digit_valid = (keypad_input < DIGIT_WIDTH'(DECIMAL_BASE));
    assign digit_ext   = DATA_WIDTH'(keypad_input);

    // x*10 built as x*8 + x*2, wraps at DATA_WIDTH
    assign times_ten  = (value << 3) + (value << 1);
    assign next_value = times_ten + digit_ext;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            value <= '0;
        end else if (clear) begin
            // A digit arriving with clear becomes the whole new operand
            if (digit_en && digit_valid) begin
                value <= digit_ext;
            end else begin
                value <= '0;
            end
        end else if (digit_en && digit_valid) begin
            value <= next_value;                       // Append digit on the right
        end
    end

endmodule

/* logic/add_sub_unit.sv */
module add_sub_unit import calc_num_pkg::*; #(
    parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH
) (
    input  logic                  clk,
    input  logic                  nRST,
    input  logic                  start,              // One-cycle start pulse
    input  logic                  subtract,           // 1 selects in_a - in_b
    input  logic [DATA_WIDTH-1:0] in_a,
    input  logic [DATA_WIDTH-1:0] in_b,
    output logic [DATA_WIDTH-1:0] result,
    output logic                  finish
);

    logic [DATA_WIDTH-1:0] sum_diff;

    // Both paths wrap modulo 2**DATA_WIDTH
    assign sum_diff = subtract ? (in_a - in_b) : (in_a + in_b);

    always_ff @(posedge clk) begin
        if (start) begin
            result <= sum_diff;                        // Captured with the start edge
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            finish <= 1'b0;
        end else begin
            finish <= start;                           // Result valid next cycle
        end
    end

endmodule

/* logic/shift_add_multiplier.sv */
module shift_add_multiplier import calc_num_pkg::*; #(
    parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH
) (
    input  logic                  clk,
    input  logic                  nRST,
    input  logic                  start,              // One-cycle start pulse
    input  logic [DATA_WIDTH-1:0] in_a,
    input  logic [DATA_WIDTH-1:0] in_b,
    output logic [DATA_WIDTH-1:0] result,
    output logic                  finish
);

    localparam int CNT_W = (DATA_WIDTH > 2) ? $clog2(DATA_WIDTH) : 1;

    logic [DATA_WIDTH-1:0] product;
    logic [DATA_WIDTH-1:0] mcand;                      // Multiplicand, shifted left
    logic [DATA_WIDTH-1:0] mplier;                     // Multiplier, shifted right
    logic [CNT_W-1:0]      remaining;                  // Iterations still to run
    logic                  busy;

    // The start edge already handles bit 0, so DATA_WIDTH-1 steps follow
    always_ff @(posedge clk) begin
        if (start) begin
            product <= in_b[0] ? in_a : '0;
            mcand   <= in_a << 1;
            mplier  <= in_b >> 1;
        end else if (busy) begin
            if (mplier[0]) begin
                product <= product + mcand;            // Low bits only, wraps
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy      <= 1'b0;
            remaining <= '0;
            finish    <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                busy      <= 1'b1;
                remaining <= CNT_W'(DATA_WIDTH - 1);
            end else if (busy) begin
                remaining <= remaining - CNT_W'(1);
                if (remaining == CNT_W'(1)) begin
                    busy   <= 1'b0;
                    finish <= 1'b1;                    // Lands DATA_WIDTH cycles after start
                end
            end
        end
    end

    assign result = product;

endmodule

/* logic/calc_controller.sv */
module calc_controller import calc_op_pkg::*; (
    input  logic clk,
    input  logic nRST,
    input  logic read_input,            // Digit strobe
    input  op_t  operator_input,
    input  logic equal_input,           // Equal strobe
    input  logic addsub_finish,
    input  logic mult_finish,
    output logic digit_en_a,
    output logic digit_en_b,
    output logic clear_operands,
    output logic start_addsub,
    output logic subtract,
    output logic start_mult,
    output logic clear_result
);

    typedef enum logic [1:0] {
        ENTER_FIRST  = 2'd0,
        ENTER_SECOND = 2'd1,
        BUSY         = 2'd2,
        SHOWN        = 2'd3
    } state_t;

    state_t state_q;
    state_t state_d;
    op_t    op_q;                       // Operator accepted during first entry
    logic   op_valid;
    logic   start_addsub_d;
    logic   start_mult_d;

    // Only the three one-hot codes count as operators
    assign op_valid = (operator_input == OP_ADD) ||
                      (operator_input == OP_SUB) ||
                      (operator_input == OP_MUL);

    always_comb begin
        state_d        = state_q;
        start_addsub_d = 1'b0;
        start_mult_d   = 1'b0;
        case (state_q)
            ENTER_FIRST: begin
                if (op_valid) begin
                    state_d = ENTER_SECOND;
                end
            end
            ENTER_SECOND: begin
                if (equal_input) begin
                    state_d        = BUSY;
                    start_mult_d   = (op_q == OP_MUL);
                    start_addsub_d = (op_q != OP_MUL);
                end
            end
            BUSY: begin
                // Strobes are dropped here until a unit reports back
                if (addsub_finish || mult_finish) begin
                    state_d = SHOWN;
                end
            end
            SHOWN: begin
                if (read_input) begin
                    state_d = ENTER_FIRST;     // That digit starts operand A
                end
            end
            default: begin
                state_d = ENTER_FIRST;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state_q      <= ENTER_FIRST;
            op_q         <= OP_ADD;
            start_addsub <= 1'b0;
            start_mult   <= 1'b0;
        end else begin
            state_q      <= state_d;
            start_addsub <= start_addsub_d;   // Start issued the cycle after equal
            start_mult   <= start_mult_d;
            if (state_q == ENTER_FIRST && op_valid) begin
                op_q <= operator_input;
            end
        end
    end

    assign subtract = (op_q == OP_SUB);

    // Digit routing acts in the same cycle as the strobe
    assign digit_en_a     = read_input && (state_q == ENTER_FIRST || state_q == SHOWN);
    assign digit_en_b     = read_input && (state_q == ENTER_SECOND);
    assign clear_operands = read_input && (state_q == SHOWN);
    assign clear_result   = read_input && (state_q == SHOWN);

endmodule

/* logic/result_display.sv */
module result_display import calc_num_pkg::*; #(
    parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH
) (
    input  logic                  clk,
    input  logic                  nRST,
    input  logic                  addsub_finish,
    input  logic                  mult_finish,
    input  logic                  clear_result,
    input  logic [DATA_WIDTH-1:0] addsub_result,
    input  logic [DATA_WIDTH-1:0] mult_result,
    output logic [DATA_WIDTH-1:0] display_output,
    output logic                  complete
);

    logic                  any_finish;
    logic [DATA_WIDTH-1:0] finished_value;

    assign any_finish     = addsub_finish || mult_finish;
    assign finished_value = mult_finish ? mult_result : addsub_result;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            display_output <= '0;
            complete       <= 1'b0;
        end else if (any_finish) begin
            display_output <= finished_value;
            complete       <= 1'b1;                    // Held until the next entry
        end else if (clear_result) begin
            complete <= 1'b0;                          // Display keeps the last result
        end
    end

endmodule

/* logic/calculator_top.sv */
module calculator_top import calc_num_pkg::*; import calc_op_pkg::*; #(
    parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH
) (
    input  logic                   clk,
    input  logic                   nRST,
    input  logic [DIGIT_WIDTH-1:0] keypad_input,
    input  logic                   read_input,
    input  op_t                    operator_input,
    input  logic                   equal_input,
    output logic                   complete,
    output logic [DATA_WIDTH-1:0]  display_output
);

    logic                  digit_en_a;
    logic                  digit_en_b;
    logic                  clear_operands;
    logic                  start_addsub;
    logic                  subtract;
    logic                  start_mult;
    logic                  clear_result;
    logic [DATA_WIDTH-1:0] value_a;
    logic [DATA_WIDTH-1:0] value_b;
    logic [DATA_WIDTH-1:0] addsub_result;
    logic                  addsub_finish;
    logic [DATA_WIDTH-1:0] mult_result;
    logic                  mult_finish;

    calc_controller u_controller (
        .clk            (clk),
        .nRST           (nRST),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .addsub_finish  (addsub_finish),
        .mult_finish    (mult_finish),
        .digit_en_a     (digit_en_a),
        .digit_en_b     (digit_en_b),
        .clear_operands (clear_operands),
        .start_addsub   (start_addsub),
        .subtract       (subtract),
        .start_mult     (start_mult),
        .clear_result   (clear_result)
    );

    digit_accumulator #(.DATA_WIDTH(DATA_WIDTH)) operand_a (
        .clk          (clk),
        .nRST         (nRST),
        .digit_en     (digit_en_a),
        .clear        (clear_operands),
        .keypad_input (keypad_input),
        .value        (value_a)
    );

    digit_accumulator #(.DATA_WIDTH(DATA_WIDTH)) operand_b (
        .clk          (clk),
        .nRST         (nRST),
        .digit_en     (digit_en_b),
        .clear        (clear_operands),
        .keypad_input (keypad_input),
        .value        (value_b)
    );

    add_sub_unit #(.DATA_WIDTH(DATA_WIDTH)) u_add_sub (
        .clk      (clk),
        .nRST     (nRST),
        .start    (start_addsub),
        .subtract (subtract),
        .in_a     (value_a),
        .in_b     (value_b),
        .result   (addsub_result),
        .finish   (addsub_finish)
    );

    shift_add_multiplier #(.DATA_WIDTH(DATA_WIDTH)) u_multiplier (
        .clk    (clk),
        .nRST   (nRST),
        .start  (start_mult),
        .in_a   (value_a),
        .in_b   (value_b),
        .result (mult_result),
        .finish (mult_finish)
    );

    result_display #(.DATA_WIDTH(DATA_WIDTH)) u_display (
        .clk            (clk),
        .nRST           (nRST),
        .addsub_finish  (addsub_finish),
        .mult_finish    (mult_finish),
        .clear_result   (clear_result),
        .addsub_result  (addsub_result),
        .mult_result    (mult_result),
        .display_output (display_output),
        .complete       (complete)
    );

endmodule

/* tb/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int PERIOD = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(PERIOD / 2) clk = ~clk;               // Half period per phase
    end

endmodule

/* tb/calculator_tb.sv */
module calculator_tb import calc_num_pkg::*, calc_op_pkg::*; ();

    localparam int DATA_WIDTH   = DEFAULT_DATA_WIDTH;
    localparam int RESET_CYCLES = 10;
    localparam int WAIT_LIMIT   = DATA_WIDTH + 8;    // Per-test wait for complete
    localparam int NOISE_KEYS   = 3;                 // Digit, operator and equal while busy

    logic                   clk;
    logic                   nRST;
    logic [DIGIT_WIDTH-1:0] keypad_input;
    logic                   read_input;
    op_t                    operator_input;
    logic                   equal_input;
    logic                   complete;
    logic [DATA_WIDTH-1:0]  display_output;

    string name_q[$];
    string a_keys_q[$];
    string op_keys_q[$];
    string b_keys_q[$];
    int    noise_q[$];
    int    expected_q[$];

    int value_errors = 0;
    int other_errors = 0;
    int cycle_count  = 0;
    int cycle_limit  = 0;

    tb_clock_gen #(.PERIOD(8)) u_clock (.clk(clk));

    calculator_top #(.DATA_WIDTH(DATA_WIDTH)) dut (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output)
    );

    // One hex character of the data file per key code
    function automatic int hex_value(input byte c);
        int v;
        v = 0;
        if (c >= 8'h30 && c <= 8'h39) begin
            v = int'(c) - 48;
        end else if (c >= 8'h61 && c <= 8'h66) begin
            v = int'(c) - 87;
        end else if (c >= 8'h41 && c <= 8'h46) begin
            v = int'(c) - 55;
        end
        return v;
    endfunction

    task automatic read_testdata();
        int    fd;
        int    fields;
        int    noise;
        int    expected;
        string line;
        string name;
        string a_keys;
        string op_keys;
        string b_keys;
        fd = $fopen("tb/calculator_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;                        // Blank or comment line
            end
            fields = $sscanf(line, "%s %s %s %s %d %d",
                             name, a_keys, op_keys, b_keys, noise, expected);
            if (fields != 6) begin
                $display("Malformed test data line: %s", line);
                other_errors++;
                continue;
            end
            name_q.push_back(name);
            a_keys_q.push_back(a_keys);
            op_keys_q.push_back(op_keys);
            b_keys_q.push_back(b_keys);
            noise_q.push_back(noise);
            expected_q.push_back(expected);
        end
        $fclose(fd);
    endtask

    // Two cycles per key, then the wait for complete
    task automatic set_cycle_limit();
        int max_keys;
        int keys;
        max_keys = 0;
        foreach (name_q[i]) begin
            keys = a_keys_q[i].len() + op_keys_q[i].len() + b_keys_q[i].len() + 1 + NOISE_KEYS;
            if (keys > max_keys) begin
                max_keys = keys;
            end
        end
        cycle_limit = name_q.size() * (2 * max_keys + WAIT_LIMIT + 4) + RESET_CYCLES + 8;
    endtask

    task automatic press_digit(input int code);
        @(posedge clk);
        keypad_input <= DIGIT_WIDTH'(code);
        read_input   <= 1'b1;
        @(posedge clk);
        read_input   <= 1'b0;                    // Next press leaves one idle cycle
    endtask

    task automatic press_operator(input int code);
        @(posedge clk);
        operator_input <= op_t'(code);
        @(posedge clk);
        operator_input <= '0;
    endtask

    task automatic press_equal();
        @(posedge clk);
        equal_input <= 1'b1;
        @(posedge clk);
        equal_input <= 1'b0;
    endtask

    // Keys that a busy calculator has to drop
    task automatic press_while_busy();
        press_digit(7);
        press_operator(int'(OP_ADD));
        press_equal();
    endtask

    task automatic wait_complete(output bit seen);
        int waited;
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
            if (complete) begin
                seen = 1'b1;
            end
        end
    endtask

    task automatic run_test(input int idx);
        bit    seen;
        string name;
        name = name_q[idx];
        for (int k = 0; k < a_keys_q[idx].len(); k++) begin
            press_digit(hex_value(a_keys_q[idx][k]));
            if (k == 0) begin
                @(negedge clk);
                if (complete) begin
                    $display("Complete still high after the first digit of %s", name);
                    other_errors++;
                end
            end
        end
        for (int k = 0; k < op_keys_q[idx].len(); k++) begin
            press_operator(hex_value(op_keys_q[idx][k]));
        end
        for (int k = 0; k < b_keys_q[idx].len(); k++) begin
            press_digit(hex_value(b_keys_q[idx][k]));
        end
        press_equal();
        if (noise_q[idx] != 0) begin
            press_while_busy();
        end
        wait_complete(seen);
        if (!seen) begin
            $display("Test %s never raised complete within %0d cycles", name, WAIT_LIMIT);
            other_errors++;
        end else if (display_output !== DATA_WIDTH'(expected_q[idx])) begin
            $display("Fail %s: expected %0d, actual %0d", name, expected_q[idx],
                     display_output);
            value_errors++;
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            other_errors++;
            $display("Run did not finish within %0d cycles", cycle_limit);
            $display("Errors: %0d wrong values, %0d other failures",
                     value_errors, other_errors);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        nRST           <= 1'b0;
        keypad_input   <= '0;
        read_input     <= 1'b0;
        operator_input <= '0;
        equal_input    <= 1'b0;
        read_testdata();
        set_cycle_limit();
        repeat (RESET_CYCLES) @(posedge clk);
        nRST <= 1'b1;
        @(negedge clk);
        if (complete !== 1'b0 || display_output !== '0) begin
            $display("Complete or display not cleared by reset");
            other_errors++;
        end
        foreach (name_q[i]) begin
            run_test(i);
        end
        repeat (4) @(posedge clk);
        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* tb/calculator_testdata.txt */
# name  operand_a_keys  operator_keys  operand_b_keys  busy_keys  expected_display
# Keys are hex codes one per character, operator codes 1 add 2 sub 4 mul, expected in decimal
add_multi 123 1 45 0 168
sub_wrap 3 2 5 0 65534
mul_wrap 300 4 300 0 24464
mul_small 12 4 34 0 408
bad_digit_a 1f2 1 3 0 15
bad_operator 7 634 8 0 56
bad_digit_b 5 2 a9 0 65532
mul_busy 250 4 250 1 62500
add_wrap 65535 1 1 0 0
mul_big 1234 4 567 0 44318
fresh_entry 4 1 5 0 9
sub_zero 0 2 0 0 0
entry_wrap 99999 1 0 0 34463
sub_plain 1000 2 1 0 999
mul_busy_small 7 4 9 1 63
mul_zero 0 4 123 0 0
mul_max 2 4 65535 0 65534
bad_op_zero 9 01 9 0 18

/* project.f */
logic/calc_num_pkg.sv
logic/calc_op_pkg.sv
logic/digit_accumulator.sv
logic/add_sub_unit.sv
logic/shift_add_multiplier.sv
logic/calc_controller.sv
logic/result_display.sv
logic/calculator_top.sv
tb/tb_clock_gen.sv
tb/calculator_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= calculator_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Verification failed
PASS_MSG  ?= Verification passed
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation gave no result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
